/* Bender.yml */
package:
  name: ecc_point_unit

sources:
  - design/ecc_pkg.sv
  - design/ecc_step_decode.sv
  - design/ecc_point_sequencer.sv
  - design/ecc_operand_regs.sv
  - design/ecc_result_stage.sv
  - design/ecc_point_unit.sv
  - target: test
    files:
      - testbench/ecc_point_unit_properties.sv
      - testbench/tb_ecc_point_unit.sv

/* design/ecc_operand_regs.sv */
`default_nettype none

module ecc_operand_regs (
    input  wire                i_clk,
    input  wire                i_reset,
    input  wire                i_load,
    input  wire                i_write,
    input  ecc_pkg::point_t    i_point,
    input  ecc_pkg::point_t    i_base,
    input  ecc_pkg::field_t    i_curve_a,
    input  ecc_pkg::micro_op_t i_uop,
    input  ecc_pkg::field_t    i_fop_result,
    output ecc_pkg::fop_req_t  o_fop,
    output ecc_pkg::point_t    o_point
);

    ecc_pkg::field_t px, py;    // working point
    ecc_pkg::field_t qx, qy;    // base point
    ecc_pkg::field_t a;
    ecc_pkg::field_t t0, t1, x3;

    function automatic ecc_pkg::field_t pick(input ecc_pkg::operand_sel_e sel);
        case (sel)
            ecc_pkg::SRC_PX: return px;
            ecc_pkg::SRC_PY: return py;
            ecc_pkg::SRC_QX: return qx;
            ecc_pkg::SRC_QY: return qy;
            ecc_pkg::SRC_A:  return a;
            ecc_pkg::SRC_T0: return t0;
            ecc_pkg::SRC_T1: return t1;
            default:         return x3;
        endcase
    endfunction

    always_comb
    begin
        o_fop.opcode = i_uop.opcode;
        o_fop.a      = pick(i_uop.src_a);
        o_fop.b      = pick(i_uop.src_b);
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            px <= '0;
            py <= '0;
            qx <= '0;
            qy <= '0;
            a  <= '0;
            t0 <= '0;
            t1 <= '0;
            x3 <= '0;
        end
        else if (i_load)
        begin
            px <= i_point.x;
            py <= i_point.y;
            qx <= i_base.x;
            qy <= i_base.y;
            a  <= i_curve_a;
        end
        else if (i_write)
        begin
            case (i_uop.dest)
                ecc_pkg::DST_T0: t0 <= i_fop_result;
                ecc_pkg::DST_T1: t1 <= i_fop_result;
                ecc_pkg::DST_X3: x3 <= i_fop_result;
                default:
                begin
                    px <= x3;               // new point becomes the working point
                    py <= i_fop_result;
                end
            endcase
        end
    end

    assign o_point = '{x: px, y: py};

endmodule

`default_nettype wire

/* design/ecc_pkg.sv */
`default_nettype none

package ecc_pkg;

    localparam int FIELD_W = 32;

    typedef logic [FIELD_W-1:0] field_t;

    typedef struct packed {
        field_t x;
        field_t y;
    } point_t;

    // encodings shared with the field unit
    typedef enum logic [1:0] {
        FOP_ADD = 2'b00,
        FOP_SUB = 2'b01,
        FOP_MUL = 2'b10,
        FOP_DIV = 2'b11
    } fop_opcode_e;

    // doubling runs 0..11 and addition follows at 12..20
    typedef enum logic [4:0] {
        DBL_0, DBL_1, DBL_2, DBL_3, DBL_4, DBL_5,
        DBL_6, DBL_7, DBL_8, DBL_9, DBL_10, DBL_11,
        ADD_0, ADD_1, ADD_2, ADD_3, ADD_4, ADD_5,
        ADD_6, ADD_7, ADD_8
    } step_e;

    typedef enum logic [2:0] {
        SRC_PX, SRC_PY, SRC_QX, SRC_QY, SRC_A, SRC_T0, SRC_T1, SRC_X3
    } operand_sel_e;

    typedef enum logic [1:0] {
        DST_T0, DST_T1, DST_X3, DST_POINT   // point writes py and copies x3 into px
    } dest_sel_e;

    typedef struct packed {
        fop_opcode_e  opcode;
        operand_sel_e src_a;
        operand_sel_e src_b;
        dest_sel_e    dest;
        logic         last_dbl;
        logic         last_add;
    } micro_op_t;

    typedef struct packed {
        fop_opcode_e opcode;
        field_t      a;
        field_t      b;
    } fop_req_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_REQ,
        SEQ_GAP,
        SEQ_FINISH
    } seq_state_e;

endpackage

`default_nettype wire

/* design/ecc_point_sequencer.sv */
`default_nettype none

module ecc_point_sequencer (
    input  wire                i_clk,
    input  wire                i_reset,
    input  wire                i_start,
    input  wire                i_key_bit,
    input  wire                i_fop_done,
    input  ecc_pkg::micro_op_t i_uop,
    output ecc_pkg::step_e     o_step,
    output logic               o_load,
    output logic               o_fop_req,
    output logic               o_write,
    output logic               o_finish,
    output logic               o_busy
);

    ecc_pkg::seq_state_e state;
    logic                key;       // key bit of the running command

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state  <= ecc_pkg::SEQ_IDLE;
            o_step <= ecc_pkg::DBL_0;
            key    <= 1'b0;
        end
        else
        begin
            case (state)
                ecc_pkg::SEQ_IDLE:
                    if (i_start)
                    begin
                        state  <= ecc_pkg::SEQ_REQ;
                        o_step <= ecc_pkg::DBL_0;
                        key    <= i_key_bit;
                    end
                ecc_pkg::SEQ_REQ:
                    if (i_fop_done)
                    begin
                        if (i_uop.last_add || (i_uop.last_dbl && !key))
                            state <= ecc_pkg::SEQ_FINISH;
                        else
                        begin
                            state <= ecc_pkg::SEQ_GAP;
                            if (i_uop.last_dbl)
                                o_step <= ecc_pkg::ADD_0;   // key bit set so add Q next
                            else
                                o_step <= ecc_pkg::step_e'(o_step + 5'd1);
                        end
                    end
                ecc_pkg::SEQ_GAP:
                    state <= ecc_pkg::SEQ_REQ;   // request drops for one cycle
                default:
                    state <= ecc_pkg::SEQ_IDLE;
            endcase
        end
    end

    assign o_load    = (state == ecc_pkg::SEQ_IDLE) && i_start;
    assign o_fop_req = (state == ecc_pkg::SEQ_REQ);
    assign o_write   = o_fop_req && i_fop_done;
    assign o_finish  = (state == ecc_pkg::SEQ_FINISH);
    assign o_busy    = (state != ecc_pkg::SEQ_IDLE);

endmodule

`default_nettype wire

/* design/ecc_point_unit.sv */
`default_nettype none

module ecc_point_unit (
    input  wire               i_clk,
    input  wire               i_reset,
    input  wire               i_start,
    input  wire               i_key_bit,
    input  ecc_pkg::point_t   i_point,
    input  ecc_pkg::point_t   i_base,
    input  ecc_pkg::field_t   i_curve_a,
    output logic              o_fop_req,
    output ecc_pkg::fop_req_t o_fop,
    input  wire               i_fop_done,
    input  ecc_pkg::field_t   i_fop_result,
    output logic              o_busy,
    output logic              o_done,
    output ecc_pkg::point_t   o_result
);

    ecc_pkg::step_e     step;
    ecc_pkg::micro_op_t uop;
    ecc_pkg::point_t    cur_point;
    logic               load;
    logic               write;
    logic               finish;

    ecc_step_decode u_decode (
        .i_step (step),
        .o_uop  (uop)
    );

    ecc_point_sequencer u_seq (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_start    (i_start),
        .i_key_bit  (i_key_bit),
        .i_fop_done (i_fop_done),
        .i_uop      (uop),
        .o_step     (step),
        .o_load     (load),
        .o_fop_req  (o_fop_req),
        .o_write    (write),
        .o_finish   (finish),
        .o_busy     (o_busy)
    );

    ecc_operand_regs u_regs (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_load       (load),
        .i_write      (write),
        .i_point      (i_point),
        .i_base       (i_base),
        .i_curve_a    (i_curve_a),
        .i_uop        (uop),
        .i_fop_result (i_fop_result),
        .o_fop        (o_fop),
        .o_point      (cur_point)
    );

    ecc_result_stage u_result (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_finish (finish),
        .i_point  (cur_point),
        .o_done   (o_done),
        .o_result (o_result)
    );

endmodule

`default_nettype wire

/* design/ecc_result_stage.sv */
`default_nettype none

module ecc_result_stage (
    input  wire             i_clk,
    input  wire             i_reset,
    input  wire             i_finish,
    input  ecc_pkg::point_t i_point,
    output logic            o_done,
    output ecc_pkg::point_t o_result
);

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            o_done   <= 1'b0;
            o_result <= '0;
        end
        else
        begin
            o_done <= i_finish;
            if (i_finish)
                o_result <= i_point;    // held until the next command ends
        end
    end

endmodule

`default_nettype wire

/* design/ecc_step_decode.sv */
`default_nettype none

module ecc_step_decode (
    input  ecc_pkg::step_e     i_step,
    output ecc_pkg::micro_op_t o_uop
);

    function automatic ecc_pkg::micro_op_t mk(
        input ecc_pkg::fop_opcode_e  op,
        input ecc_pkg::operand_sel_e a,
        input ecc_pkg::operand_sel_e b,
        input ecc_pkg::dest_sel_e    d
    );
        return '{opcode: op, src_a: a, src_b: b, dest: d, last_dbl: 1'b0, last_add: 1'b0};
    endfunction

    always_comb
    begin
        case (i_step)
            // doubling slope is (3x^2 + a) / 2y
            ecc_pkg::DBL_0:
                o_uop = mk(ecc_pkg::FOP_MUL, ecc_pkg::SRC_PX, ecc_pkg::SRC_PX, ecc_pkg::DST_T0);
            ecc_pkg::DBL_1:
                o_uop = mk(ecc_pkg::FOP_ADD, ecc_pkg::SRC_T0, ecc_pkg::SRC_T0, ecc_pkg::DST_T1);
            ecc_pkg::DBL_2:
                o_uop = mk(ecc_pkg::FOP_ADD, ecc_pkg::SRC_T0, ecc_pkg::SRC_T1, ecc_pkg::DST_T0);
            ecc_pkg::DBL_3:
                o_uop = mk(ecc_pkg::FOP_ADD, ecc_pkg::SRC_T0, ecc_pkg::SRC_A, ecc_pkg::DST_T0);
            ecc_pkg::DBL_4:
                o_uop = mk(ecc_pkg::FOP_ADD, ecc_pkg::SRC_PY, ecc_pkg::SRC_PY, ecc_pkg::DST_T1);
            ecc_pkg::DBL_5:
                o_uop = mk(ecc_pkg::FOP_DIV, ecc_pkg::SRC_T0, ecc_pkg::SRC_T1, ecc_pkg::DST_T0);
            ecc_pkg::DBL_6:
                o_uop = mk(ecc_pkg::FOP_MUL, ecc_pkg::SRC_T0, ecc_pkg::SRC_T0, ecc_pkg::DST_T1);
            ecc_pkg::DBL_7:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_T1, ecc_pkg::SRC_PX, ecc_pkg::DST_T1);
            ecc_pkg::DBL_8:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_T1, ecc_pkg::SRC_PX, ecc_pkg::DST_X3);
            ecc_pkg::DBL_9:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_PX, ecc_pkg::SRC_X3, ecc_pkg::DST_T1);
            ecc_pkg::DBL_10:
                o_uop = mk(ecc_pkg::FOP_MUL, ecc_pkg::SRC_T0, ecc_pkg::SRC_T1, ecc_pkg::DST_T1);
            ecc_pkg::DBL_11:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_T1, ecc_pkg::SRC_PY, ecc_pkg::DST_POINT);
            // addition slope is (qy - py) / (qx - px)
            ecc_pkg::ADD_0:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_QX, ecc_pkg::SRC_PX, ecc_pkg::DST_T0);
            ecc_pkg::ADD_1:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_QY, ecc_pkg::SRC_PY, ecc_pkg::DST_T1);
            ecc_pkg::ADD_2:
                o_uop = mk(ecc_pkg::FOP_DIV, ecc_pkg::SRC_T1, ecc_pkg::SRC_T0, ecc_pkg::DST_T0);
            ecc_pkg::ADD_3:
                o_uop = mk(ecc_pkg::FOP_MUL, ecc_pkg::SRC_T0, ecc_pkg::SRC_T0, ecc_pkg::DST_T1);
            ecc_pkg::ADD_4:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_T1, ecc_pkg::SRC_PX, ecc_pkg::DST_T1);
            ecc_pkg::ADD_5:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_T1, ecc_pkg::SRC_QX, ecc_pkg::DST_X3);
            ecc_pkg::ADD_6:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_PX, ecc_pkg::SRC_X3, ecc_pkg::DST_T1);
            ecc_pkg::ADD_7:
                o_uop = mk(ecc_pkg::FOP_MUL, ecc_pkg::SRC_T0, ecc_pkg::SRC_T1, ecc_pkg::DST_T1);
            ecc_pkg::ADD_8:
                o_uop = mk(ecc_pkg::FOP_SUB, ecc_pkg::SRC_T1, ecc_pkg::SRC_PY, ecc_pkg::DST_POINT);
            default:
                o_uop = mk(ecc_pkg::FOP_ADD, ecc_pkg::SRC_T0, ecc_pkg::SRC_T0, ecc_pkg::DST_T0);
        endcase
        o_uop.last_dbl = (i_step == ecc_pkg::DBL_11);
        o_uop.last_add = (i_step == ecc_pkg::ADD_8);
    end

endmodule

`default_nettype wire

/* ecc_point_unit.f */
design/ecc_pkg.sv
design/ecc_step_decode.sv
design/ecc_point_sequencer.sv
design/ecc_operand_regs.sv
design/ecc_result_stage.sv
design/ecc_point_unit.sv
testbench/ecc_point_unit_properties.sv
testbench/tb_ecc_point_unit.sv

/* testbench/ecc_point_unit_properties.sv */
`default_nettype none

module ecc_point_unit_properties (
    input wire               i_clk,
    input wire               i_reset,
    input wire               o_fop_req,
    input ecc_pkg::fop_req_t o_fop,
    input wire               i_fop_done,
    input wire               o_done
);

    fop_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_fop_req && !i_fop_done) |=> $stable(o_fop))
        else $error("field request changed while waiting for done");

    req_gap: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_fop_req && i_fop_done) |=> !o_fop_req)
        else $error("request not dropped in the cycle after done");

    done_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |=> !o_done)
        else $error("o_done held for more than one cycle");

    // outputs follow the async reset at once
    reset_quiet: assert property (@(posedge i_clk)
        i_reset |-> (!o_fop_req && !o_done))
        else $error("request or done high during reset");

endmodule

bind ecc_point_unit ecc_point_unit_properties u_props (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .o_fop_req  (o_fop_req),
    .o_fop      (o_fop),
    .i_fop_done (i_fop_done),
    .o_done     (o_done)
);

`default_nettype wire

/* testbench/tb_ecc_point_unit.sv */
`default_nettype none

module tb_ecc_point_unit;

    localparam int          CLK_PERIOD = 100;
    localparam logic [31:0] P_MOD      = 32'hFFFF_FFFB;
    localparam logic [31:0] SEED       = 32'hf793_d0dc;
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam int          MAX_LAT    = 8;
    localparam int          NUM_CMDS   = 12;
    localparam int          WATCHDOG_CYCLES = NUM_CMDS * 21 * (MAX_LAT + 2) + NUM_CMDS * 40 + 100;

    logic                i_clk;
    logic                i_reset;
    logic                i_start;
    logic                i_key_bit;
    ecc_pkg::point_t     i_point;
    ecc_pkg::point_t     i_base;
    ecc_pkg::field_t     i_curve_a;
    logic                o_fop_req;
    ecc_pkg::fop_req_t   o_fop;
    logic                i_fop_done;
    ecc_pkg::field_t     i_fop_result;
    logic                o_busy;
    logic                o_done;
    ecc_pkg::point_t     o_result;

    logic [31:0] lfsr;
    int          err;
    int          tests_failed;
    int          cyc;
    int          last_done_cyc;
    int          done_cnt;
    int          req_idx;       // requests seen in the running command
    int          wait_left;
    logic        active;
    logic        long_lat;

    ecc_point_unit i_dut (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_start      (i_start),
        .i_key_bit    (i_key_bit),
        .i_point      (i_point),
        .i_base       (i_base),
        .i_curve_a    (i_curve_a),
        .o_fop_req    (o_fop_req),
        .o_fop        (o_fop),
        .i_fop_done   (i_fop_done),
        .i_fop_result (i_fop_result),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .o_result     (o_result)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] draw_field();
        logic [31:0] v;
        v = take_bits(32);
        return (v >= P_MOD) ? v - P_MOD : v;
    endfunction

    function automatic logic [31:0] f_add(input logic [31:0] x, input logic [31:0] y);
        logic [32:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, P_MOD})
            s = s - {1'b0, P_MOD};
        return s[31:0];
    endfunction

    function automatic logic [31:0] f_sub(input logic [31:0] x, input logic [31:0] y);
        return (x >= y) ? x - y : x - y + P_MOD;   // wraps back into range
    endfunction

    function automatic logic [31:0] f_mul(input logic [31:0] x, input logic [31:0] y);
        logic [63:0] pr;
        pr = 64'(x) * 64'(y);
        return 32'(pr % 64'(P_MOD));
    endfunction

    // fermat inverse as x^(p-2)
    function automatic logic [31:0] f_inv(input logic [31:0] x);
        logic [31:0] r;
        logic [31:0] b;
        logic [31:0] e;
        r = 32'd1;
        b = x;
        e = P_MOD - 32'd2;
        while (e != 0)
        begin
            if (e[0])
                r = f_mul(r, b);
            b = f_mul(b, b);
            e = e >> 1;
        end
        return r;
    endfunction

    function automatic ecc_pkg::point_t model_double(input ecc_pkg::point_t p,
                                                    input logic [31:0] a);
        logic [31:0] xx;
        logic [31:0] l;
        ecc_pkg::point_t r;
        xx  = f_mul(p.x, p.x);
        l   = f_mul(f_add(f_add(f_add(xx, xx), xx), a), f_inv(f_add(p.y, p.y)));
        r.x = f_sub(f_sub(f_mul(l, l), p.x), p.x);
        r.y = f_sub(f_mul(l, f_sub(p.x, r.x)), p.y);
        return r;
    endfunction

    function automatic ecc_pkg::point_t model_add(input ecc_pkg::point_t p,
                                                 input ecc_pkg::point_t q);
        logic [31:0] l;
        ecc_pkg::point_t r;
        l   = f_mul(f_sub(q.y, p.y), f_inv(f_sub(q.x, p.x)));
        r.x = f_sub(f_sub(f_mul(l, l), p.x), q.x);
        r.y = f_sub(f_mul(l, f_sub(p.x, r.x)), p.y);
        return r;
    endfunction

    // opcode order of the doubling then addition microprogram
    function automatic ecc_pkg::fop_opcode_e expected_opcode(input int idx);
        case (idx)
            0, 6, 10, 15, 19: return ecc_pkg::FOP_MUL;
            1, 2, 3, 4:       return ecc_pkg::FOP_ADD;
            5, 14:            return ecc_pkg::FOP_DIV;
            default:          return ecc_pkg::FOP_SUB;
        endcase
    endfunction

    always @(posedge i_clk)
        cyc <= cyc + 1;

    // field unit model with random latency
    always @(posedge i_clk)
    begin
        if (i_reset)
        begin
            i_fop_done <= 1'b0;
            active = 1'b0;
            wait_left = 0;
        end
        else if (i_fop_done)
        begin
            i_fop_done    <= 1'b0;
            last_done_cyc <= cyc;
            active = 1'b0;
        end
        else if (o_fop_req)
        begin
            if (!active)
            begin
                active = 1'b1;
                if (o_fop.opcode !== expected_opcode(req_idx))
                begin
                    err = err + 1;
                    $display("mismatch o_fop.opcode at request %0d: expected %h, got %h",
                             req_idx, expected_opcode(req_idx), o_fop.opcode);
                end
                req_idx = req_idx + 1;
                case (o_fop.opcode)
                    ecc_pkg::FOP_ADD: i_fop_result <= f_add(o_fop.a, o_fop.b);
                    ecc_pkg::FOP_SUB: i_fop_result <= f_sub(o_fop.a, o_fop.b);
                    ecc_pkg::FOP_MUL: i_fop_result <= f_mul(o_fop.a, o_fop.b);
                    default:          i_fop_result <= f_mul(o_fop.a, f_inv(o_fop.b));
                endcase
                wait_left = long_lat ? 4 + int'(take_bits(2)) : int'(take_bits(3));
            end
            else
                wait_left = wait_left - 1;
            if (wait_left == 0)
                i_fop_done <= 1'b1;
        end
    end

    always @(posedge i_clk)
    begin
        if (!i_reset && o_done)
        begin
            done_cnt <= done_cnt + 1;
            if (cyc - last_done_cyc != 2)
            begin
                err = err + 1;
                $display("o_done came %0d cycles after the last field done, not 2",
                         cyc - last_done_cyc);
            end
        end
    end

    task automatic run_cmd(input int num, input string name, input int mode, input logic key);
        ecc_pkg::point_t p;
        ecc_pkg::point_t q;
        ecc_pkg::point_t other;
        ecc_pkg::point_t exp_pt;
        logic [31:0]     a;
        int              err_before;
        int              exp_reqs;
        logic            busy_bad;
        err_before = err;
        exp_reqs   = key ? 21 : 12;
        long_lat   = (mode == 2);
        do
        begin
            p.x    = draw_field();
            p.y    = draw_field();
            q.x    = draw_field();
            q.y    = draw_field();
            a      = draw_field();
            exp_pt = model_double(p, a);
        end while (p.y == 0 || (key && exp_pt.x == q.x));   // no zero denominators
        if (key)
            exp_pt = model_add(exp_pt, q);
        other = '0;
        if (mode == 1)
        begin
            other.x = draw_field();
            other.y = draw_field();
        end
        req_idx  = 0;
        done_cnt = 0;
        @(posedge i_clk);
        i_start   <= 1'b1;
        i_key_bit <= key;
        i_point   <= p;
        i_base    <= q;
        i_curve_a <= a;
        @(posedge i_clk);
        i_start <= 1'b0;
        if (mode == 1)
        begin
            @(posedge i_clk);
            i_start   <= 1'b1;      // ignored while the DUT is busy
            i_key_bit <= ~key;
            i_point   <= other;
            @(posedge i_clk);
            i_start <= 1'b0;
        end
        if (mode == 3)
        begin
            while (req_idx < 5)
                @(negedge i_clk);
            @(posedge i_clk);
            i_reset <= 1'b1;
            @(posedge i_clk);
            if (o_busy || o_fop_req || o_done)
            begin
                err = err + 1;
                $display("reset in mid-command left busy, request or done high");
            end
            i_reset <= 1'b0;
            @(posedge i_clk);
        end
        else
        begin
            busy_bad = 1'b0;
            while (!o_done)
            begin
                @(posedge i_clk);
                if (o_busy == o_done)
                    busy_bad = 1'b1;
            end
            if (busy_bad)
            begin
                err = err + 1;
                $display("o_busy did not stay high through the command and fall with o_done");
            end
            if (o_result !== exp_pt)
            begin
                err = err + 1;
                $display("mismatch o_result: expected %h, got %h", exp_pt, o_result);
            end
            repeat (4) @(posedge i_clk);
            if (req_idx != exp_reqs)
            begin
                err = err + 1;
                $display("mismatch request count: expected %h, got %h", exp_reqs, req_idx);
            end
            if (done_cnt != 1)
            begin
                err = err + 1;
                $display("expected one done pulse but saw %0d", done_cnt);
            end
            if (o_busy)
            begin
                err = err + 1;
                $display("busy still high after the command finished");
            end
        end
        if (err == err_before)
            $display("test %0d %s: pass", num, name);
        else
        begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: fail", num, name);
        end
    endtask

    initial
    begin
        i_reset      = 1'b1;
        i_start      = 1'b0;
        i_key_bit    = 1'b0;
        i_point      = '0;
        i_base       = '0;
        i_curve_a    = '0;
        i_fop_done   = 1'b0;
        i_fop_result = '0;
        lfsr          = SEED;
        err           = 0;
        tests_failed  = 0;
        cyc           = 0;
        last_done_cyc = 0;
        done_cnt      = 0;
        req_idx       = 0;
        wait_left     = 0;
        active        = 1'b0;
        long_lat      = 1'b0;
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
        for (int n = 0; n < NUM_CMDS; n++)
        begin
            if (n < 3)
                run_cmd(n, "double only", 0, 1'b0);
            else if (n < 6)
                run_cmd(n, "double and add", 0, 1'b1);
            else if (n < 8)
                run_cmd(n, "start while busy", 1, take_bits(1) != 32'd0);
            else if (n < 10)
                run_cmd(n, "long latency", 2, take_bits(1) != 32'd0);
            else if (n == 10)
                run_cmd(n, "reset mid-command", 3, 1'b1);
            else
                run_cmd(n, "command after reset", 0, take_bits(1) != 32'd0);
        end
        $display("tests %0d, failed %0d, errors %0d", NUM_CMDS, tests_failed, err);
        if (err == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
